/* common/lc3b_types.sv */
package lc3b_types;

	localparam int word_w = 16; // data path width
	localparam int reg_idx_w = 3; // register index bits
	localparam int num_regs = 8; // r0..r7
	localparam int mdu_steps = 16; // one iteration per operand bit
	localparam int mdu_cnt_w = $clog2(mdu_steps); // iteration counter width

	// 4-bit opcode field, instr[15:12]
	typedef enum logic [3:0]
	{
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_xor = 4'b1001, // also covers not with imm5 = -1
		op_shf = 4'b1101,
		op_mult = 4'b1010, // reserved slot in base isa
		op_div = 4'b1011 // reserved slot in base isa
	} lc3b_opcode;

	// operation handed from decode to execute
	typedef enum logic [3:0]
	{
		alu_add,
		alu_and,
		alu_xor,
		alu_pass, // f = b
		alu_sll,
		alu_srl,
		alu_sra,
		alu_mult, // handled by div_mult_unit
		alu_div // handled by div_mult_unit
	} lc3b_aluop;

	// iterative unit sequencing
	typedef enum logic [1:0]
	{
		mdu_idle,
		mdu_run,
		mdu_done
	} mdu_state;

endpackage : lc3b_types

/* execute/alu.sv */
`timescale 1ns/10ps

module alu
(
	input lc3b_types::lc3b_aluop aluop,
	input logic [lc3b_types::word_w-1:0] a,
	input logic [lc3b_types::word_w-1:0] b,
	output logic [lc3b_types::word_w-1:0] f
);
	import lc3b_types::*;

	logic [3:0] shamt; // shifts use low nibble only

	assign shamt = b[3:0];

	always_comb
	begin
		case (aluop)
			alu_add: f = a + b;
			alu_and: f = a & b;
			alu_xor: f = a ^ b; // not when b is all ones
			alu_pass: f = b;
			alu_sll: f = a << shamt;
			alu_srl: f = a >> shamt;
			alu_sra: f = $signed(a) >>> shamt; // sign fills from the top
			default: f = '0; // mult / div come from the iterative unit
		endcase
	end

endmodule : alu

/* execute/div_mult_unit.sv */
`timescale 1ns/10ps

module div_mult_unit
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input lc3b_types::lc3b_aluop aluop,
	input logic [lc3b_types::word_w-1:0] a,
	input logic [lc3b_types::word_w-1:0] b,
	output logic done,
	output logic [lc3b_types::word_w-1:0] result
);
	import lc3b_types::*;

	mdu_state state_q; // state register
	logic [mdu_cnt_w-1:0] cnt_q; // iteration counter
	logic is_div_q; // latched at start, aluop may move on
	logic [word_w-1:0] opnd_q; // multiplicand (shifts left) or divisor
	logic [word_w-1:0] shf_q; // multiplier (shifts right) or dividend (shifts left)
	logic [word_w-1:0] rem_q; // partial remainder
	logic [word_w-1:0] sol_q; // solution register, product or quotient
	logic [word_w:0] rem_sh; // remainder with next dividend bit, one extra bit
	logic [word_w:0] rem_diff; // trial subtract
	logic ge; // divisor fits

	assign rem_sh = {rem_q, shf_q[word_w-1]};
	assign rem_diff = rem_sh - {1'b0, opnd_q};
	assign ge = rem_sh >= {1'b0, opnd_q}; // zero divisor always fits, quotient 0xffff
	assign done = (state_q == mdu_done);
	assign result = sol_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= mdu_idle;
			cnt_q <= '0;
		end
		else
		begin
			case (state_q)
				mdu_idle:
				if (start)
				begin
					state_q <= mdu_run;
					cnt_q <= '0;
				end
				mdu_run:
				begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == mdu_cnt_w'(mdu_steps - 1))
						state_q <= mdu_done; // last step taken
				end
				default: state_q <= mdu_idle; // done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state_q == mdu_idle && start)
		begin
			is_div_q <= (aluop == alu_div);
			opnd_q <= b; // divisor, or multiplicand swapped in below
			shf_q <= a;
			rem_q <= '0;
			sol_q <= '0;
			if (aluop == alu_mult)
			begin
				opnd_q <= a; // multiplicand
				shf_q <= b; // multiplier, scanned lsb first
			end
		end
		else if (state_q == mdu_run)
		begin
			if (is_div_q)
			begin
				shf_q <= shf_q << 1; // next dividend bit into view
				sol_q <= {sol_q[word_w-2:0], ge};
				rem_q <= ge ? rem_diff[word_w-1:0] : rem_sh[word_w-1:0]; // restore on miss
			end
			else
			begin
				if (shf_q[0])
					sol_q <= sol_q + opnd_q; // low 16 bits of product
				opnd_q <= opnd_q << 1;
				shf_q <= shf_q >> 1;
			end
		end
	end

	// execute must hold off until the unit is free, and done follows at a fixed distance
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> state_q == mdu_idle ##(mdu_steps + 1) done);

endmodule : div_mult_unit

/* execute/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage
(
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input lc3b_types::lc3b_aluop issue_aluop,
	input logic [lc3b_types::reg_idx_w-1:0] issue_dest,
	input logic [lc3b_types::word_w-1:0] issue_a,
	input logic [lc3b_types::word_w-1:0] issue_b,
	output logic issue_ready,
	output logic ex_valid,
	output logic [lc3b_types::reg_idx_w-1:0] ex_dest,
	output logic [lc3b_types::word_w-1:0] ex_data,
	output logic ex_busy,
	output logic [lc3b_types::reg_idx_w-1:0] ex_busy_dest
);
	import lc3b_types::*;

	logic slot_valid; // item held in execute
	logic slot_mdu; // item waits on the iterative unit
	logic [reg_idx_w-1:0] slot_dest;
	logic [word_w-1:0] slot_data; // registered alu result
	logic [word_w-1:0] alu_f;
	logic [word_w-1:0] mdu_result;
	logic mdu_done;
	logic is_mdu; // incoming op goes to the unit
	logic issue_fire;

	assign is_mdu = (issue_aluop == alu_mult) || (issue_aluop == alu_div);
	assign issue_fire = issue_valid && issue_ready;
	assign ex_valid = slot_valid && (!slot_mdu || mdu_done); // result stage always takes it
	assign issue_ready = !slot_valid || (ex_valid && !slot_mdu); // unit must be idle before a new start
	assign ex_dest = slot_dest;
	assign ex_data = slot_mdu ? mdu_result : slot_data;
	assign ex_busy = slot_valid; // running unit or held alu result
	assign ex_busy_dest = slot_dest;

	alu u_alu
	(
		.aluop(issue_aluop),
		.a(issue_a),
		.b(issue_b),
		.f(alu_f)
	);

	div_mult_unit u_div_mult
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(issue_fire && is_mdu),
		.aluop(issue_aluop),
		.a(issue_a),
		.b(issue_b),
		.done(mdu_done),
		.result(mdu_result)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			slot_valid <= 1'b0;
			slot_mdu <= 1'b0;
		end
		else if (issue_fire)
		begin
			slot_valid <= 1'b1;
			slot_mdu <= is_mdu;
		end
		else if (ex_valid)
			slot_valid <= 1'b0; // item left for write-back
	end

	always_ff @(posedge clk)
	begin
		if (issue_fire)
		begin
			slot_dest <= issue_dest;
			slot_data <= alu_f; // unused for mult / div
		end
	end

	// an alu result handed on never coincides with a mult or div finishing in the unit
	a_alu_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid && !slot_mdu |-> !mdu_done);

endmodule : execute_stage

/* source/instr_decode.sv */
`timescale 1ns/10ps

module instr_decode
(
	input logic clk,
	input logic rst_n,
	input logic [lc3b_types::word_w-1:0] instr,
	input logic instr_valid,
	input logic issue_ready,
	input logic ex_busy,
	input logic [lc3b_types::reg_idx_w-1:0] ex_busy_dest,
	input logic [lc3b_types::word_w-1:0] rd_data_a,
	input logic [lc3b_types::word_w-1:0] rd_data_b,
	output logic instr_ready,
	output logic issue_valid,
	output lc3b_types::lc3b_aluop issue_aluop,
	output logic [lc3b_types::reg_idx_w-1:0] issue_dest,
	output logic [lc3b_types::word_w-1:0] issue_a,
	output logic [lc3b_types::word_w-1:0] issue_b,
	output logic [lc3b_types::reg_idx_w-1:0] rd_idx_a,
	output logic [lc3b_types::reg_idx_w-1:0] rd_idx_b
);
	import lc3b_types::*;

	logic held_valid; // one instruction slot
	logic [word_w-1:0] instr_q; // held instruction word
	logic op_known; // opcode is one we execute
	logic uses_b; // sr2 register is a real source
	logic hazard; // a source is still in flight in execute
	logic drop; // unknown opcode leaves without issue

	assign rd_idx_a = instr_q[8:6]; // sr1 / shift source
	assign rd_idx_b = instr_q[2:0]; // sr2
	assign issue_dest = instr_q[11:9]; // dr
	assign issue_a = rd_data_a;

	always_comb
	begin
		op_known = 1'b1;
		uses_b = !instr_q[5]; // bit 5 selects imm5
		issue_aluop = alu_add;
		issue_b = instr_q[5] ? {{(word_w-5){instr_q[4]}}, instr_q[4:0]} : rd_data_b; // sext imm5
		case (lc3b_opcode'(instr_q[15:12]))
			op_add: issue_aluop = alu_add;
			op_and: issue_aluop = alu_and;
			op_xor: issue_aluop = alu_xor;
			op_mult: issue_aluop = alu_mult;
			op_div: issue_aluop = alu_div;
			op_shf:
			begin
				uses_b = 1'b0; // amount is in the word itself
				issue_b = {{(word_w-4){1'b0}}, instr_q[3:0]};
				if (!instr_q[4])
					issue_aluop = alu_sll; // lshf
				else if (instr_q[5])
					issue_aluop = alu_sra; // rshfa
				else
					issue_aluop = alu_srl; // rshfl
			end
			default: op_known = 1'b0; // dropped after one cycle
		endcase
	end

	assign hazard = ex_busy && ((rd_idx_a == ex_busy_dest) || (uses_b && rd_idx_b == ex_busy_dest));
	assign issue_valid = held_valid && op_known && !hazard;
	assign drop = held_valid && !op_known;
	assign instr_ready = !held_valid || (issue_valid && issue_ready) || drop; // slot frees this cycle

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			held_valid <= 1'b0;
		else if (instr_valid && instr_ready)
			held_valid <= 1'b1; // accept edge
		else if ((issue_valid && issue_ready) || drop)
			held_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (instr_valid && instr_ready)
			instr_q <= instr;
	end

	// nothing may be offered to execute straight out of a reset cycle
	a_no_issue_in_reset: assert property (@(posedge clk) !rst_n |=> !issue_valid);

endmodule : instr_decode

/* source/reg_file.sv */
`timescale 1ns/10ps

module reg_file
(
	input logic clk,
	input logic rst_n,
	input logic [lc3b_types::reg_idx_w-1:0] rd_idx_a,
	input logic [lc3b_types::reg_idx_w-1:0] rd_idx_b,
	input logic wr_en,
	input logic [lc3b_types::reg_idx_w-1:0] wr_idx,
	input logic [lc3b_types::word_w-1:0] wr_data,
	output logic [lc3b_types::word_w-1:0] rd_data_a,
	output logic [lc3b_types::word_w-1:0] rd_data_b
);
	import lc3b_types::*;

	logic [word_w-1:0] regs [num_regs]; // r0..r7

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0; // architectural state starts at zero
		end
		else if (wr_en)
			regs[wr_idx] <= wr_data;
	end

	// write-through so the result stage needs no interlock
	assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
	assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule : reg_file

/* source/result_stage.sv */
`timescale 1ns/10ps

module result_stage
(
	input logic clk,
	input logic rst_n,
	input logic ex_valid,
	input logic [lc3b_types::reg_idx_w-1:0] ex_dest,
	input logic [lc3b_types::word_w-1:0] ex_data,
	output logic wb_valid,
	output logic [lc3b_types::reg_idx_w-1:0] wb_reg,
	output logic [lc3b_types::word_w-1:0] wb_data
);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= ex_valid; // never stalls, one item per cycle
	end

	always_ff @(posedge clk)
	begin
		if (ex_valid)
		begin
			wb_reg <= ex_dest;
			wb_data <= ex_data;
		end
	end

endmodule : result_stage

/* source/lc3b_exec_core.sv */
`timescale 1ns/10ps

module lc3b_exec_core
(
	input logic clk,
	input logic rst_n,
	input logic [lc3b_types::word_w-1:0] instr,
	input logic instr_valid,
	output logic instr_ready,
	output logic wb_valid,
	output logic [lc3b_types::reg_idx_w-1:0] wb_reg,
	output logic [lc3b_types::word_w-1:0] wb_data
);
	import lc3b_types::*;

	logic issue_valid, issue_ready;
	lc3b_aluop issue_aluop;
	logic [reg_idx_w-1:0] issue_dest, rd_idx_a, rd_idx_b, ex_dest, ex_busy_dest;
	logic [word_w-1:0] issue_a, issue_b, rd_data_a, rd_data_b, ex_data;
	logic ex_valid, ex_busy;

	instr_decode u_decode
	(
		.clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
		.issue_ready(issue_ready), .ex_busy(ex_busy), .ex_busy_dest(ex_busy_dest),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .instr_ready(instr_ready),
		.issue_valid(issue_valid), .issue_aluop(issue_aluop), .issue_dest(issue_dest),
		.issue_a(issue_a), .issue_b(issue_b), .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b)
	);

	reg_file u_regs
	(
		.clk(clk), .rst_n(rst_n), .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
		.wr_en(wb_valid), .wr_idx(wb_reg), .wr_data(wb_data), // written from the result stage
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
	);

	execute_stage u_execute
	(
		.clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_aluop(issue_aluop),
		.issue_dest(issue_dest), .issue_a(issue_a), .issue_b(issue_b),
		.issue_ready(issue_ready), .ex_valid(ex_valid), .ex_dest(ex_dest), .ex_data(ex_data),
		.ex_busy(ex_busy), .ex_busy_dest(ex_busy_dest)
	);

	result_stage u_result
	(
		.clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_dest(ex_dest), .ex_data(ex_data),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

endmodule : lc3b_exec_core

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk); // five cycles in reset
		#1;
		rst_n = 1'b1; // released just after the fifth edge, like any other input
	end

endmodule : tb_clock_gen

/* verif/lc3b_exec_core_tb.sv */
`timescale 1ns/10ps

module lc3b_exec_core_tb;
	import lc3b_types::*;

	localparam int n_directed = 15;
	localparam int n_rand = 60;
	localparam int timeout_cycles = (num_regs + n_directed + n_rand) * 20 + 50;

	logic clk, rst_n;
	logic [15:0] instr;
	logic instr_valid;
	logic instr_ready, wb_valid;
	logic [2:0] wb_reg;
	logic [15:0] wb_data;

	logic [15:0] lfsr; // galois state
	logic [15:0] model_regs [8]; // architectural register model
	logic [2:0] exp_reg_mem [256]; // expected writebacks, in order
	logic [15:0] exp_data_mem [256];
	int head = 0; // next expected writeback
	int tail = 0; // next free slot
	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	logic [2:0] head_reg;
	logic [15:0] head_data;
	logic acc_alu, acc_mdu; // accept edge of a single-cycle / iterative op

	tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

	lc3b_exec_core uut
	(
		.clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
		.instr_ready(instr_ready), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	assign head_reg = exp_reg_mem[head];
	assign head_data = exp_data_mem[head];
	assign acc_alu = instr_valid && instr_ready && (instr[15:12] inside {op_add, op_and, op_xor, op_shf});
	assign acc_mdu = instr_valid && instr_ready && (instr[15:12] inside {op_mult, op_div});

	// one lfsr step per bit taken, lsb first
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1); // x^16+x^14+x^13+x^11+1
		end
		return bits;
	endfunction

	// isa rules applied to the model on each accept
	task automatic model_accept(input logic [15:0] w);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [31:0] prod;
		logic known;
		a = model_regs[w[8:6]];
		b = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]]; // imm5 or sr2
		known = 1'b1;
		res = '0;
		case (w[15:12])
			op_add: res = a + b;
			op_and: res = a & b;
			op_xor: res = a ^ b;
			op_shf:
			begin
				if (!w[4])
					res = a << w[3:0];
				else if (w[5])
					res = $signed(a) >>> w[3:0]; // arithmetic
				else
					res = a >> w[3:0];
			end
			op_mult:
			begin
				prod = a * b;
				res = prod[15:0]; // low half only
			end
			op_div: res = (b == 16'd0) ? 16'hffff : a / b;
			default: known = 1'b0; // no writeback
		endcase
		if (known)
		begin
			model_regs[w[11:9]] = res;
			exp_reg_mem[tail] = w[11:9];
			exp_data_mem[tail] = res;
			tail = tail + 1;
		end
	endtask

	// hold the word until accepted, ready looked at mid-cycle
	task automatic send(input logic [15:0] w);
		logic rdy;
		instr = w;
		instr_valid = 1'b1;
		rdy = 1'b0;
		while (!rdy)
		begin
			@(negedge clk);
			rdy = instr_ready;
			@(posedge clk);
		end
		model_accept(w);
		#1;
		instr_valid = 1'b0;
	endtask

	task automatic idle(input int n);
		instr_valid = 1'b0;
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic drain();
		instr_valid = 1'b0;
		while (head != tail)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	always @(posedge clk)
	begin
		if (rst_n && wb_valid)
			head <= head + 1; // retire in order
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles)
		begin
			$display("timeout: run still going after %0d cycles", timeout_cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	a_wb_expected: assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> head != tail)
	else
	begin
		other_errors++;
		$display("Error at %0t: writeback with no instruction outstanding", $time);
	end

	a_wb_reg: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid && head != tail |-> wb_reg == head_reg)
	else
	begin
		value_errors++;
		$display("Error at %0t: wb_reg got %0d expected %0d", $time, $sampled(wb_reg), $sampled(head_reg));
	end

	a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid && head != tail |-> wb_data == head_data)
	else
	begin
		value_errors++;
		$display("Error at %0t: wb_data got %h expected %h", $time, $sampled(wb_data), $sampled(head_data));
	end

	a_alu_latency: assert property (@(posedge clk) disable iff (!rst_n)
		acc_alu && head == tail |-> ##1 !wb_valid ##1 !wb_valid ##1 wb_valid)
	else
	begin
		other_errors++;
		$display("Error at %0t: alu result not written 3 cycles after accept", $time);
	end

	a_mdu_latency: assert property (@(posedge clk) disable iff (!rst_n)
		acc_mdu && head == tail |-> ##1 (!wb_valid)[*18] ##1 wb_valid)
	else
	begin
		other_errors++;
		$display("Error at %0t: mult/div result not written 19 cycles after accept", $time);
	end

	a_reset_wb: assert property (@(posedge clk) !rst_n |=> !wb_valid)
	else
	begin
		other_errors++;
		$display("Error at %0t: wb_valid got %b expected 0 in reset", $time, $sampled(wb_valid));
	end

	a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> instr_ready)
	else
	begin
		other_errors++;
		$display("Error at %0t: instr_ready got 0 expected 1 after reset", $time);
	end

	initial
	begin
		logic [15:0] rnd;
		logic [3:0] opc;
		instr = '0;
		instr_valid = 1'b0;
		lfsr = 16'd19213;
		for (int r = 0; r < num_regs; r++)
			model_regs[r] = '0;
		@(posedge rst_n);
		@(posedge clk);
		#1;
		for (int r = 0; r < num_regs; r++)
		begin
			rnd = take_bits(5);
			send({op_add, 3'(r), 3'(r), 1'b1, rnd[4:0]}); // rN = 0 + imm5
		end
		drain();
		send(16'h1242); // add r1, r1, r2 into an empty pipe
		drain();
		send(16'ha644); // mult r3, r1, r4 into an empty pipe
		drain();
		send(16'hbac2); // div r5, r3, r2
		send(16'h5da0); // and r6, r6, #0
		send(16'hbe46); // div r7, r1, r6 zero divisor right behind its producer
		idle(2);
		send(16'h947f); // not r2, r1
		send(16'h1082); // add r0, r2, r2 dependent
		send(16'hd803); // lshf r4, r0, #3
		send(16'hd935); // rshfa r4, r4, #5
		idle(3);
		send(16'ha300); // mult r1, r4, r0
		send(16'hd652); // rshfl r3, r1, #2 waits on the multiply
		send(16'h2abc); // ldb, dropped
		send(16'he5ff); // lea, dropped
		send(16'h1ae7); // add r5, r3, #7
		send(16'h0000); // br, dropped
		for (int i = 0; i < n_rand; i++)
		begin
			rnd = take_bits(3);
			case (rnd[2:0])
				3'd0: opc = op_add;
				3'd1: opc = op_and;
				3'd2: opc = op_xor;
				3'd3: opc = op_shf;
				3'd4: opc = op_mult;
				3'd5: opc = op_div;
				3'd6: opc = op_add;
				default: opc = 4'b0111; // stw, dropped
			endcase
			rnd = take_bits(12);
			send({opc, rnd[11:0]});
			rnd = take_bits(2);
			if (rnd[1:0] == 2'b11)
			begin
				rnd = take_bits(1);
				idle(1 + rnd[0]); // valid gap
			end
		end
		drain();
		idle(4);
		assert (head == tail)
		else
		begin
			other_errors++;
			$display("writebacks %0d do not match %0d expected results", head, tail);
		end
		$display("errors: %0d value, %0d other, writebacks %0d of %0d",
			value_errors, other_errors, head, tail);
		if (value_errors + other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule : lc3b_exec_core_tb

/* lc3b_exec_core.f */
common/lc3b_types.sv
execute/alu.sv
execute/div_mult_unit.sv
execute/execute_stage.sv
source/instr_decode.sv
source/reg_file.sv
source/result_stage.sv
source/lc3b_exec_core.sv
verif/tb_clock_gen.sv
verif/lc3b_exec_core_tb.sv
